/* common/fetch_cfg.svh */
/*
 * Build-time constants for the block fetch subsystem.
 * Register offsets match the low address byte seen by the slave port.
 * Include wherever an offset, the block limit or a GPIO pin is needed.
 */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Longest block the master will read, in 32-bit words
`define FETCH_MAX_LEN 256

`define REG_CTRL     8'h00 // W: bit 0 start, bit 1 clear done
`define REG_ADDR     8'h04 // Start byte address
`define REG_LEN      8'h08 // Word count, clamped
`define REG_STATUS   8'h0C // Bit 0 busy, bit 1 done
`define REG_SUM      8'h10
`define REG_XOR      8'h14
`define REG_PEAK     8'h18
`define REG_PEAK_IDX 8'h1C

`define GPIO_BUSY_PIN 5 // Fetch in progress
`define GPIO_DONE_PIN 6 // Results ready
`endif

/* common/team_02_pkg.sv */
/*
 * Shared packed structs for the fetch core and its register block.
 * Modules refer to these by scoped name only.
 */
package team_02_pkg;

    // Command latched at start, handed to the bus master
    typedef struct packed {
        logic [31:0] start_addr; // Byte address, word aligned
        logic [8:0]  len;        // Words, 1 .. 256
    } fetch_cmd_t;

    // One fetched word as seen by the reduction units
    typedef struct packed {
        logic [31:0] data;
        logic [7:0]  index; // Position in block
        logic        last;  // Final word of block
    } fetch_word_t;

    // Checksum pair
    typedef struct packed {
        logic [31:0] sum;     // Wraparound sum
        logic [31:0] xor_val; // XOR of all words
    } checksum_t;

    // Largest unsigned word and where it first appeared
    typedef struct packed {
        logic [31:0] value;
        logic [7:0]  index;
    } peak_t;

    // Merged record, read back by software
    typedef struct packed {
        checksum_t cks;
        peak_t     peak;
    } block_result_t;

endpackage

/* team_02_wb/team_02_wb.sv */
/*
 * Wishbone slave register block of the fetch subsystem.
 * Holds start address and length, issues start and clear pulses
 * and returns status and merged results with a single-cycle ack.
 */
`include "fetch_cfg.svh"

module team_02_wb (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       stb_i,
    input  logic                       cyc_i,
    input  logic                       we_i,
    input  logic [3:0]                 sel_i,
    input  logic [31:0]                adr_i,
    input  logic [31:0]                dat_i,
    input  logic                       busy_i,
    input  logic                       done_i,
    input  team_02_pkg::block_result_t result_i,
    output logic                       ack_o,
    output logic [31:0]                dat_o,
    output logic                       start_o,
    output team_02_pkg::fetch_cmd_t    cmd_o,
    output logic                       done_clr_o
);

    logic        access;            // Transfer taken this cycle
    logic        wr_ctrl, wr_addr, wr_len;
    logic [31:0] addr_q;
    logic [8:0]  len_q;
    logic [31:0] len_old;           // Length widened to bus width
    logic [31:0] addr_new, len_new; // Byte-merged write values
    logic [8:0]  len_clamped;
    logic [31:0] rd_data;

    assign access  = stb_i & cyc_i & ~ack_o;
    assign wr_ctrl = access & we_i & (adr_i[7:0] == `REG_CTRL);
    assign wr_addr = access & we_i & (adr_i[7:0] == `REG_ADDR);
    assign wr_len  = access & we_i & (adr_i[7:0] == `REG_LEN);
    assign len_old = {23'b0, len_q};

    // Merge selected bytes over the current contents
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            addr_new[8*b +: 8] = sel_i[b] ? dat_i[8*b +: 8] : addr_q[8*b +: 8];
            len_new[8*b +: 8]  = sel_i[b] ? dat_i[8*b +: 8] : len_old[8*b +: 8];
        end
    end

    assign len_clamped = (len_new > `FETCH_MAX_LEN) ? 9'(`FETCH_MAX_LEN) : len_new[8:0];

    always_comb begin
        case (adr_i[7:0])
            `REG_ADDR:     rd_data = addr_q;
            `REG_LEN:      rd_data = len_old;
            `REG_STATUS:   rd_data = {30'b0, done_i, busy_i};
            `REG_SUM:      rd_data = result_i.cks.sum;
            `REG_XOR:      rd_data = result_i.cks.xor_val;
            `REG_PEAK:     rd_data = result_i.peak.value;
            `REG_PEAK_IDX: rd_data = {24'b0, result_i.peak.index};
            default:       rd_data = '0; // CTRL is write only
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o      <= 1'b0;
            start_o    <= 1'b0;
            done_clr_o <= 1'b0;
            addr_q     <= '0;
            len_q      <= '0;
        end else begin
            ack_o      <= access;
            // No start while a block is running or nothing to fetch
            start_o    <= wr_ctrl & sel_i[0] & dat_i[0] & ~busy_i & (len_q != 9'd0);
            done_clr_o <= wr_ctrl & sel_i[0] & dat_i[1];
            if (wr_addr) addr_q <= addr_new;
            if (wr_len)  len_q  <= len_clamped;
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk_i) begin
        if (access && !we_i) dat_o <= rd_data;
    end

    assign cmd_o = '{start_addr: addr_q, len: len_q};

    // Single-cycle ack, so back-to-back strobes see a gap
    a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_o |=> !ack_o);

endmodule

/* fetch/wbm_fetch.sv */
/*
 * Wishbone read master for one block of 32-bit words.
 * Keeps a single request outstanding and hands each acked word,
 * with its index and last flag, to the reduction units.
 */
`include "fetch_cfg.svh"

module wbm_fetch (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  team_02_pkg::fetch_cmd_t  cmd_i,
    input  logic                     ack_i,
    input  logic [31:0]              dat_i,
    output logic [31:0]              adr_o,
    output logic [31:0]              dat_o,
    output logic [3:0]               sel_o,
    output logic                     we_o,
    output logic                     stb_o,
    output logic                     cyc_o,
    output logic                     word_valid_o,
    output team_02_pkg::fetch_word_t word_o
);

    localparam int IDX_W = $clog2(`FETCH_MAX_LEN); // 8 bits of word index

    typedef enum logic {
        IDLE,
        READ
    } state_t;

    state_t           state_q;
    logic [31:0]      adr_q;
    logic [IDX_W-1:0] idx_q;   // Word now on the bus
    logic [IDX_W:0]   len_q;   // Block length from command
    logic             xfer;    // Word accepted this cycle
    logic             last_word;

    assign xfer      = (state_q == READ) & ack_i;
    assign last_word = ({1'b0, idx_q} == len_q - 1'b1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            adr_q   <= '0;
            idx_q   <= '0;
            len_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        adr_q   <= cmd_i.start_addr;
                        len_q   <= cmd_i.len;
                        idx_q   <= '0;
                        state_q <= READ; // Strobe one cycle after start
                    end
                end
                READ: begin
                    if (ack_i) begin
                        if (last_word) begin
                            state_q <= IDLE; // Bus released after final ack
                        end else begin
                            adr_q <= adr_q + 32'd4;
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Read-only, full word
    assign adr_o = adr_q;
    assign dat_o = '0;
    assign sel_o = 4'hF;
    assign we_o  = 1'b0;
    assign stb_o = (state_q == READ);
    assign cyc_o = (state_q == READ);

    // Word passes straight through on the ack cycle
    assign word_valid_o = xfer;
    assign word_o       = '{data: dat_i, index: idx_q, last: last_word};

    // Request held steady inside the cycle until the slave acks
    a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_o && !ack_i |=> stb_o && cyc_o && $stable(adr_o));

endmodule

/* fetch/block_checksum.sv */
/*
 * Running wraparound sum and XOR over one fetched block.
 * Cleared by start, result valid pulses the cycle after the last word.
 */
module block_checksum (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic                     word_valid_i,
    input  team_02_pkg::fetch_word_t word_i,
    output logic                     sum_valid_o,
    output team_02_pkg::checksum_t   sum_o
);

    logic [31:0] sum_q;
    logic [31:0] xor_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= word_valid_i & word_i.last;
        end
    end

    // Accumulators
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            sum_q <= '0;
            xor_q <= '0;
        end else if (word_valid_i) begin
            sum_q <= sum_q + word_i.data; // Carry out dropped
            xor_q <= xor_q ^ word_i.data;
        end
    end

    assign sum_o = '{sum: sum_q, xor_val: xor_q};

endmodule

/* fetch/block_peak.sv */
/*
 * Tracks the largest unsigned word of a block and its index.
 * Only a strictly larger word replaces the peak, so ties keep
 * the first occurrence. Result valid follows the last word by a cycle.
 */
module block_peak (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic                     word_valid_i,
    input  team_02_pkg::fetch_word_t word_i,
    output logic                     peak_valid_o,
    output team_02_pkg::peak_t       peak_o
);

    logic [31:0] peak_q;
    logic [7:0]  idx_q;
    logic        load;   // Take the incoming word as new peak

    // First word of a block always loads
    assign load = word_valid_i &
                  ((word_i.index == 8'd0) | (word_i.data > peak_q));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            peak_valid_o <= 1'b0;
        end else begin
            peak_valid_o <= word_valid_i & word_i.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            peak_q <= '0;
            idx_q  <= '0;
        end else if (load) begin
            peak_q <= word_i.data;
            idx_q  <= word_i.index;
        end
    end

    assign peak_o = '{value: peak_q, index: idx_q};

endmodule

/* fetch/result_merge.sv */
/*
 * Joins checksum and peak into one result record.
 * Owns the busy and done flags; the interrupt level follows done
 * until software clears it or a new block starts.
 */
module result_merge (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  logic                       done_clr_i,
    input  logic                       sum_valid_i,
    input  team_02_pkg::checksum_t     sum_i,
    input  logic                       peak_valid_i,
    input  team_02_pkg::peak_t         peak_i,
    output team_02_pkg::block_result_t result_o,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       irq_o
);

    logic res_valid; // Both reductions finished

    assign res_valid = sum_valid_i & peak_valid_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else if (start_i) begin
            busy_o <= 1'b1;
            done_o <= 1'b0; // Stale results no longer flagged
        end else if (res_valid) begin
            busy_o <= 1'b0;
            done_o <= 1'b1;
        end else if (done_clr_i) begin
            done_o <= 1'b0;
        end
    end

    // Record held until the next block completes
    always_ff @(posedge clk_i) begin
        if (res_valid) result_o <= '{cks: sum_i, peak: peak_i};
    end

    assign irq_o = done_o;

    // Both units see the same last word, so they finish together
    a_valid_align: assert property (@(posedge clk_i) disable iff (rst_i)
        sum_valid_i == peak_valid_i);

    // Results only arrive for a block that was started
    a_valid_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        sum_valid_i |-> busy_o);

endmodule

/* source/team_02_wrapper.sv */
/*
 * Top level of the team user block in the harness.
 * Connects the slave register block, the fetch master, both reductions
 * and the merge stage, and maps busy and done onto GPIO pins.
 */
`include "fetch_cfg.svh"

module team_02_wrapper (
    input  logic        wb_clk_i,
    input  logic        rst_i,
    // Wishbone slave from the management core
    input  logic        wbs_stb_i,
    input  logic        wbs_cyc_i,
    input  logic        wbs_we_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_dat_i,
    input  logic [31:0] wbs_adr_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    // Wishbone master towards memory
    output logic [31:0] wbm_adr_o,
    output logic [31:0] wbm_dat_o,
    output logic [3:0]  wbm_sel_o,
    output logic        wbm_we_o,
    output logic        wbm_stb_o,
    output logic        wbm_cyc_o,
    input  logic        wbm_ack_i,
    input  logic [31:0] wbm_dat_i,
    // Pads, no inputs consumed by this block
    input  logic [37:0] gpio_in_i,
    output logic [37:0] gpio_out_o,
    output logic [37:0] gpio_oeb_o, // Active low enable
    output logic [2:0]  irq_o
);

    logic                        start, done_clr, busy, done, irq;
    logic                        word_valid, sum_valid, peak_valid;
    team_02_pkg::fetch_cmd_t     cmd;
    team_02_pkg::fetch_word_t    word;
    team_02_pkg::checksum_t      cks;
    team_02_pkg::peak_t          peak;
    team_02_pkg::block_result_t  result;

    team_02_wb u_wb (
        .clk_i(wb_clk_i), .rst_i(rst_i),
        .stb_i(wbs_stb_i), .cyc_i(wbs_cyc_i), .we_i(wbs_we_i),
        .sel_i(wbs_sel_i), .adr_i(wbs_adr_i), .dat_i(wbs_dat_i),
        .busy_i(busy), .done_i(done), .result_i(result),
        .ack_o(wbs_ack_o), .dat_o(wbs_dat_o),
        .start_o(start), .cmd_o(cmd), .done_clr_o(done_clr)
    );

    wbm_fetch u_fetch (
        .clk_i(wb_clk_i), .rst_i(rst_i), .start_i(start), .cmd_i(cmd),
        .ack_i(wbm_ack_i), .dat_i(wbm_dat_i),
        .adr_o(wbm_adr_o), .dat_o(wbm_dat_o), .sel_o(wbm_sel_o), .we_o(wbm_we_o),
        .stb_o(wbm_stb_o), .cyc_o(wbm_cyc_o),
        .word_valid_o(word_valid), .word_o(word)
    );

    block_checksum u_cks (
        .clk_i(wb_clk_i), .rst_i(rst_i), .start_i(start),
        .word_valid_i(word_valid), .word_i(word),
        .sum_valid_o(sum_valid), .sum_o(cks)
    );

    block_peak u_peak (
        .clk_i(wb_clk_i), .rst_i(rst_i), .start_i(start),
        .word_valid_i(word_valid), .word_i(word),
        .peak_valid_o(peak_valid), .peak_o(peak)
    );

    result_merge u_merge (
        .clk_i(wb_clk_i), .rst_i(rst_i), .start_i(start), .done_clr_i(done_clr),
        .sum_valid_i(sum_valid), .sum_i(cks), .peak_valid_i(peak_valid), .peak_i(peak),
        .result_o(result), .busy_o(busy), .done_o(done), .irq_o(irq)
    );

    // Only the two status pins drive, everything else stays an input
    assign gpio_out_o = (38'(busy) << `GPIO_BUSY_PIN) | (38'(done) << `GPIO_DONE_PIN);
    assign gpio_oeb_o = ~((38'd1 << `GPIO_BUSY_PIN) | (38'd1 << `GPIO_DONE_PIN));
    assign irq_o      = {2'b00, irq}; // Upper lines unused

endmodule

/* verif/tb_mem_model.sv */
/*
 * Wishbone memory slave for the testbench, read-only classic cycles.
 * Each request waits 0 to 3 cycles, drawn from a Galois LFSR.
 * Contents are loaded by the testbench before reset is released.
 */
module tb_mem_model #(
    parameter int WORDS = 1024
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    output int          protocol_errs_o // Bad requests seen
);

    localparam logic [31:0] LFSR_TAPS = 32'hB4BC_D35C; // Maximal 32-bit Galois taps
    localparam int          AW        = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic [31:0] lfsr;
    logic        pending;  // Request seen, wait states running
    logic [1:0]  wait_cnt; // Wait states still to go

    initial lfsr = 32'd92750;

    // Two LFSR bits per request, one step per bit
    function automatic logic [1:0] draw_wait();
        logic [1:0] w;
        w = '0;
        for (int i = 0; i < 2; i++) begin
            w    = {w[0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1;
        end
        return w;
    endfunction

    always @(posedge clk_i) begin : serve
        logic [1:0] w;
        int         errs;
        if (rst_i) begin
            ack_o           <= 1'b0;
            pending         <= 1'b0;
            wait_cnt        <= '0;
            protocol_errs_o <= 0;
        end else begin
            ack_o <= 1'b0;
            errs  = 0;
            // Ack cycle itself never starts a new request
            if (cyc_i && stb_i && !ack_o) begin
                if (!pending) begin
                    w = draw_wait(); // New request
                    if (we_i) begin
                        errs++;
                        $display("Memory model at %0t: write request, memory is read only",
                                 $time);
                    end
                    if (adr_i[1:0] != 2'b00) begin
                        errs++;
                        $display("Memory model at %0t: address %h is not word aligned",
                                 $time, adr_i);
                    end
                    if (adr_i >= 32'(WORDS * 4)) begin
                        errs++;
                        $display("Memory model at %0t: address %h lies outside memory",
                                 $time, adr_i);
                    end
                end else begin
                    w = wait_cnt;
                end
                if (w == 2'd0) begin
                    ack_o   <= 1'b1;
                    dat_o   <= mem[adr_i[AW+1:2]];
                    pending <= 1'b0;
                end else begin
                    wait_cnt <= w - 2'd1;
                    pending  <= 1'b1;
                end
            end
            protocol_errs_o <= protocol_errs_o + errs;
        end
    end

endmodule

/* verif/tb_team_02.sv */
/*
 * Testbench for the block fetch user block.
 * Configures fetches over the slave port, serves the master from a
 * memory model with random wait states and checks every result
 * against values computed from its own copy of memory.
 */
`include "fetch_cfg.svh"

module tb_team_02;

    localparam logic [31:0] WB_BASE        = 32'h3000_0000; // Slave window
    localparam logic [31:0] LFSR_TAPS      = 32'hB4BC_D35C;
    localparam int          MEM_WORDS      = 1024;
    localparam int          TIMEOUT_CYCLES = (16 + 256 + 8 + 32) * 6 + 2000;

    logic        clk = 1'b0;
    logic        rst;
    logic        wbs_stb, wbs_cyc, wbs_we, wbs_ack;
    logic [3:0]  wbs_sel;
    logic [31:0] wbs_adr, wbs_dat_w, wbs_dat_r;
    logic        wbm_we, wbm_stb, wbm_cyc, wbm_ack;
    logic [3:0]  wbm_sel;
    logic [31:0] wbm_adr, wbm_dat_w, wbm_dat_r;
    logic [37:0] gpio_in, gpio_out, gpio_oeb;
    logic [2:0]  irq;
    int          protocol_errs;

    logic [31:0] ref_mem [MEM_WORDS]; // Expected memory contents
    logic [31:0] lfsr;
    logic [31:0] adr_seen [$];        // Master address of each acked read
    int          cyc_starts;          // Master bus cycles opened
    logic        cyc_prev;
    int          check_errs, other_errs, cycles;

    team_02_wrapper u_team_02_wrapper (
        .wb_clk_i(clk), .rst_i(rst),
        .wbs_stb_i(wbs_stb), .wbs_cyc_i(wbs_cyc), .wbs_we_i(wbs_we), .wbs_sel_i(wbs_sel),
        .wbs_dat_i(wbs_dat_w), .wbs_adr_i(wbs_adr), .wbs_ack_o(wbs_ack), .wbs_dat_o(wbs_dat_r),
        .wbm_adr_o(wbm_adr), .wbm_dat_o(wbm_dat_w), .wbm_sel_o(wbm_sel), .wbm_we_o(wbm_we),
        .wbm_stb_o(wbm_stb), .wbm_cyc_o(wbm_cyc), .wbm_ack_i(wbm_ack), .wbm_dat_i(wbm_dat_r),
        .gpio_in_i(gpio_in), .gpio_out_o(gpio_out), .gpio_oeb_o(gpio_oeb), .irq_o(irq)
    );

    tb_mem_model #(.WORDS(MEM_WORDS)) u_mem (
        .clk_i(clk), .rst_i(rst), .cyc_i(wbm_cyc), .stb_i(wbm_stb), .we_i(wbm_we),
        .adr_i(wbm_adr), .ack_o(wbm_ack), .dat_o(wbm_dat_r), .protocol_errs_o(protocol_errs)
    );

    always #50 clk = ~clk;

    // Bus monitor and run limit, sampled mid-cycle
    always @(negedge clk) begin
        cycles++;
        if (wbm_cyc && wbm_stb && wbm_ack) begin
            adr_seen.push_back(wbm_adr);
            check_word("master byte selects", 32'(wbm_sel), 32'hF); // Full word reads
            check_word("master write data", wbm_dat_w, 32'd0);       // Read-only master
        end
        if (wbm_cyc && !cyc_prev) cyc_starts++;
        cyc_prev = wbm_cyc;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1;
        end
        return r;
    endfunction

    // Wraparound sum and XOR of a block
    function automatic team_02_pkg::checksum_t expected_checksum(input int base, input int len);
        team_02_pkg::checksum_t c;
        c = '0;
        for (int i = 0; i < len; i++) begin
            c.sum     = c.sum + ref_mem[base + i];
            c.xor_val = c.xor_val ^ ref_mem[base + i];
        end
        return c;
    endfunction

    // Largest unsigned word, first index on ties
    function automatic team_02_pkg::peak_t expected_peak(input int base, input int len);
        team_02_pkg::peak_t p;
        p.value = ref_mem[base];
        p.index = 8'd0;
        for (int i = 1; i < len; i++) begin
            if (ref_mem[base + i] > p.value) begin
                p.value = ref_mem[base + i];
                p.index = 8'(i);
            end
        end
        return p;
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_checksum(input string what, input team_02_pkg::checksum_t got,
                                  input team_02_pkg::checksum_t exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s, sum %h xor %h, expected sum %h xor %h",
                     $time, what, got.sum, got.xor_val, exp.sum, exp.xor_val);
        end
    endtask

    task automatic check_peak(input string what, input team_02_pkg::peak_t got,
                              input team_02_pkg::peak_t exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s, peak %h at %0d, expected %h at %0d",
                     $time, what, got.value, got.index, exp.value, exp.index);
        end
    endtask

    task automatic bus_write(input logic [7:0] offs, input logic [31:0] data,
                             input logic [3:0] sel);
        @(negedge clk);
        wbs_adr   = WB_BASE | 32'(offs);
        wbs_dat_w = data;
        wbs_sel   = sel;
        wbs_we    = 1'b1;
        wbs_stb   = 1'b1;
        wbs_cyc   = 1'b1;
        do @(negedge clk); while (!wbs_ack);
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] offs, output logic [31:0] data);
        @(negedge clk);
        wbs_adr = WB_BASE | 32'(offs);
        wbs_sel = 4'hF;
        wbs_we  = 1'b0;
        wbs_stb = 1'b1;
        wbs_cyc = 1'b1;
        do @(negedge clk); while (!wbs_ack);
        data    = wbs_dat_r; // Valid with ack
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
    endtask

    // Busy must hold until irq rises
    task automatic wait_done(input string what);
        @(negedge clk);
        while (!irq[0]) begin
            if (!gpio_out[`GPIO_BUSY_PIN]) begin
                other_errs++;
                $display("Error at %0t: busy pin dropped before done in %s", $time, what);
            end
            @(negedge clk);
        end
    endtask

    task automatic check_results(input string what, input int base, input int len);
        team_02_pkg::checksum_t cks;
        team_02_pkg::peak_t     pk;
        logic [31:0]            rd;
        // Done pin only, busy released
        check_word({what, " gpio outputs"}, gpio_out[31:0], 32'd1 << `GPIO_DONE_PIN);
        bus_read(`REG_SUM, rd);
        cks.sum = rd;
        bus_read(`REG_XOR, rd);
        cks.xor_val = rd;
        bus_read(`REG_PEAK, rd);
        pk.value = rd;
        bus_read(`REG_PEAK_IDX, rd);
        pk.index = rd[7:0];
        check_checksum({what, " checksum"}, cks, expected_checksum(base, len));
        check_peak({what, " peak"}, pk, expected_peak(base, len));
        bus_read(`REG_STATUS, rd);
        check_word({what, " status"}, rd, 32'h2); // Done, not busy
    endtask

    // Full fetch with address sequence check
    task automatic run_block(input string what, input logic [31:0] addr, input int len);
        bus_write(`REG_ADDR, addr, 4'hF);
        bus_write(`REG_LEN, 32'(len), 4'hF);
        adr_seen.delete();
        bus_write(`REG_CTRL, 32'h1, 4'hF);
        wait_done(what);
        check_results(what, int'(addr >> 2), len);
        check_word({what, " read count"}, 32'(adr_seen.size()), 32'(len));
        foreach (adr_seen[i]) check_word({what, " address"}, adr_seen[i], addr + 32'(4 * i));
    endtask

    task automatic test_reset_regs();
        logic [31:0] rd;
        check_word("idle pins", {24'b0, wbs_ack, wbm_cyc, wbm_stb, irq,
                   gpio_out[`GPIO_BUSY_PIN], gpio_out[`GPIO_DONE_PIN]}, 32'd0);
        check_word("gpio outputs", gpio_out[31:0], 32'd0);
        check_word("output enables", gpio_oeb[31:0], 32'hFFFF_FF9F); // Pins 5 and 6 driven
        // Upper pads undriven, enables high
        check_word("upper pads", {20'b0, gpio_oeb[37:32], gpio_out[37:32]}, 32'h0000_0FC0);
        bus_write(`REG_ADDR, 32'h1234_5678, 4'hF);
        bus_read(`REG_ADDR, rd);
        check_word("address readback", rd, 32'h1234_5678);
        bus_write(`REG_ADDR, 32'hAABB_CCDD, 4'b0101); // Bytes 0 and 2 only
        bus_read(`REG_ADDR, rd);
        check_word("address byte select", rd, 32'h12BB_56DD);
        bus_write(`REG_LEN, 32'h20, 4'hF);
        bus_read(`REG_LEN, rd);
        check_word("length readback", rd, 32'h20);
        bus_write(`REG_LEN, 32'd300, 4'hF);
        bus_read(`REG_LEN, rd);
        check_word("length clamp", rd, 32'd`FETCH_MAX_LEN);
        bus_read(`REG_STATUS, rd);
        check_word("status after reset", rd, 32'd0);
    endtask

    task automatic test_peak_tie();
        logic [31:0] rd;
        ref_mem[770]   = 32'hFFFF_FFFF; // Same maximum twice in the block
        ref_mem[773]   = 32'hFFFF_FFFF;
        u_mem.mem[770] = 32'hFFFF_FFFF;
        u_mem.mem[773] = 32'hFFFF_FFFF;
        run_block("peak tie", 32'h0C00, 8);
        bus_read(`REG_PEAK_IDX, rd);
        check_word("peak tie first index", rd, 32'd2);
    endtask

    task automatic test_busy_and_clear();
        logic [31:0] rd;
        int          starts;
        bus_write(`REG_ADDR, 32'h0200, 4'hF);
        bus_write(`REG_LEN, 32'd32, 4'hF);
        adr_seen.delete();
        bus_write(`REG_CTRL, 32'h1, 4'hF);
        bus_read(`REG_STATUS, rd);
        check_word("status while busy", rd, 32'h1);
        bus_write(`REG_ADDR, 32'h0800, 4'hF); // Second command, start ignored
        bus_write(`REG_LEN, 32'd4, 4'hF);
        bus_write(`REG_CTRL, 32'h1, 4'hF);
        wait_done("busy start");
        check_results("busy start", 32'h0200 >> 2, 32);
        check_word("busy start read count", 32'(adr_seen.size()), 32'd32);
        bus_write(`REG_CTRL, 32'h2, 4'hF); // Clear done
        for (int i = 0; i < 8 && irq[0]; i++) @(negedge clk);
        if (irq[0]) begin
            other_errs++;
            $display("Error at %0t: irq_o[0] still high after a CTRL clear", $time);
        end
        bus_write(`REG_LEN, 32'd0, 4'hF);
        starts = cyc_starts;
        bus_write(`REG_CTRL, 32'h1, 4'hF);
        repeat (20) @(negedge clk); // Window for a wrongly started fetch
        check_word("master cycles for length 0", 32'(cyc_starts - starts), 32'd0);
        check_word("busy pin for length 0", 32'(gpio_out[`GPIO_BUSY_PIN]), 32'd0);
    endtask

    initial begin
        rst        = 1'b1;
        wbs_stb    = 1'b0;
        wbs_cyc    = 1'b0;
        wbs_we     = 1'b0;
        wbs_sel    = 4'h0;
        wbs_adr    = '0;
        wbs_dat_w  = '0;
        gpio_in    = '0;
        lfsr       = 32'd92750;
        check_errs = 0;
        other_errs = 0;
        cycles     = 0;
        cyc_starts = 0;
        cyc_prev   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i]   = random_bits(32);
            u_mem.mem[i] = ref_mem[i];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_regs();
        run_block("short block", 32'h0100, 16);
        run_block("long block", 32'h0400, 256);
        test_peak_tie();
        test_busy_and_clear();

        $display("Errors: %0d check, %0d memory protocol, %0d other",
                 check_errs, protocol_errs, other_errs);
        if (check_errs + protocol_errs + other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/team_02_pkg.sv
team_02_wb/team_02_wb.sv
fetch/wbm_fetch.sv
fetch/block_checksum.sv
fetch/block_peak.sv
fetch/result_merge.sv
source/team_02_wrapper.sv
verif/tb_mem_model.sv
verif/tb_team_02.sv
